/* filelist.f */
+incdir+tests
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_core.sv
tests/tb_cpu_core.sv

/* Makefile */
BUILD := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check the log"
	@echo "  clean  remove the build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f filelist.f --top-module tb_cpu_core -Mdir $(BUILD) -o sim
	./$(BUILD)/sim | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_isa_model.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int RAND_WORDS = 40;
// random part, then LI base, eight dump stores and the self loop
localparam int PROG_WORDS = RAND_WORDS + 10;
localparam data_t FILL_MASK = 16'h5A5A;
localparam instr_t NOP_WORD = {OP_NOP, 11'd0};

instr_t prog [PROG_WORDS];
data_t  model_regs [NUM_REGS];
data_t  model_mem [data_t];
data_t  exp_store_adr [$];
data_t  exp_store_dat [$];
data_t  exp_load_adr [$];

// forward branches only, never landing inside the tail
task automatic build_program();
    reg_addr_t  rx;
    reg_addr_t  ry;
    reg_addr_t  rz;
    logic [7:0] imm;
    int         kind;
    int         room;
    int         off;
    for (int i = 0; i < RAND_WORDS; i++) begin
        rx   = 3'($urandom_range(0, 7));
        ry   = 3'($urandom_range(0, 7));
        rz   = 3'($urandom_range(0, 7));
        imm  = 8'($urandom);
        kind = int'($urandom_range(0, 9));
        room = RAND_WORDS - 1 - i;
        case (kind)
            1: prog[i] = {OP_LI, rx, ($urandom_range(0, 1) != 0) ? 8'h00 : imm};
            2: prog[i] = {OP_ADDIU, rx, imm};
            3: prog[i] = {OP_RRR, rx, ry, rz, ($urandom_range(0, 1) != 0) ? FN_SUBU : FN_ADDU};
            4: prog[i] = {OP_LOGIC, rx, ry, ($urandom_range(0, 1) != 0) ? FN_OR : FN_AND};
            5, 9: prog[i] = {OP_LW, rx, ry, imm[4:0]};
            6: prog[i] = {OP_SW, rx, ry, imm[4:0]};
            7, 8: begin
                if (room == 0) begin
                    prog[i] = NOP_WORD;
                end else begin
                    off     = int'($urandom_range(1, (room < 3) ? room : 3));
                    prog[i] = (kind == 7) ? {OP_BEQZ, rx, 8'(off)} : {OP_B, 11'(off)};
                end
            end
            default: prog[i] = NOP_WORD;
        endcase
    end
    prog[RAND_WORDS] = {OP_LI, 3'd7, 8'hF0};
    for (int r = 0; r < NUM_REGS; r++) begin
        prog[RAND_WORDS + 1 + r] = {OP_SW, 3'd7, 3'(r), 5'(r)};
    end
    prog[PROG_WORDS - 1] = {OP_B, 11'h7FF};
endtask

// sequential ISA execution up to the self loop
task automatic run_model();
    instr_t    w;
    reg_addr_t rx;
    reg_addr_t ry;
    reg_addr_t rz;
    data_t     adr;
    int        pc;
    int        steps;
    pc    = 0;
    steps = 0;
    for (int r = 0; r < NUM_REGS; r++) begin
        model_regs[r] = '0;
    end
    while (pc != PROG_WORDS - 1) begin
        w   = prog[pc];
        rx  = w[10:8];
        ry  = w[7:5];
        rz  = w[4:2];
        adr = model_regs[rx] + {{11{w[4]}}, w[4:0]};
        pc  = pc + 1;
        case (opcode_e'(w[15:11]))
            OP_LI:    model_regs[rx] = {8'h00, w[7:0]};
            OP_ADDIU: model_regs[rx] = model_regs[rx] + {{8{w[7]}}, w[7:0]};
            OP_RRR: begin
                model_regs[rz] = (w[1:0] == FN_SUBU) ? model_regs[rx] - model_regs[ry]
                                                     : model_regs[rx] + model_regs[ry];
            end
            OP_LOGIC: begin
                model_regs[rx] = (w[4:0] == FN_OR) ? (model_regs[rx] | model_regs[ry])
                                                   : (model_regs[rx] & model_regs[ry]);
            end
            OP_LW: begin
                exp_load_adr.push_back(adr);
                model_regs[ry] = model_mem.exists(adr) ? model_mem[adr] : (adr ^ FILL_MASK);
            end
            OP_SW: begin
                model_mem[adr] = model_regs[ry];
                exp_store_adr.push_back(adr);
                exp_store_dat.push_back(model_regs[ry]);
            end
            OP_BEQZ: begin
                if (model_regs[rx] == '0) begin
                    pc = pc + int'($signed(w[7:0]));
                end
            end
            OP_B:    pc = pc + int'($signed(w[10:0]));
            default: pc = pc;
        endcase
        steps++;
        if (steps > 1000 || pc >= PROG_WORDS) begin
            fail_run("reference model ran away from the program");
        end
    end
endtask

`endif

/* tests/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam data_t RESET_PC = 16'h0040;

    logic   clk_50MHz;
    logic   rst;
    instr_t imem_data;
    data_t  wb_rdata = '0;
    logic   wb_ack = 1'b0;
    data_t  imem_addr;
    logic   wb_cyc;
    logic   wb_stb;
    logic   wb_we;
    data_t  wb_adr;
    data_t  wb_wdata;

    data_t       fetch_index;
    int unsigned wait_table [64];
    logic [5:0]  wait_index = '0;
    int unsigned wait_left;
    logic        busy = 1'b0;
    data_t       req_adr;
    logic        req_we;
    data_t       slave_mem [data_t];

    `include "tb_isa_model.svh"

    cpu_core #(.RESET_PC(RESET_PC)) cpu_core_inst (.*);

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    task automatic check_value(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // instruction memory reads NOP past the program
    assign fetch_index = imem_addr - RESET_PC;
    assign imem_data   = (fetch_index < 16'(PROG_WORDS)) ? prog[fetch_index[5:0]] : NOP_WORD;

    // ******************************
    // wishbone slave
    task automatic start_request();
        busy      = 1'b1;
        req_adr   = wb_adr;
        req_we    = wb_we;
        wait_left = wait_table[wait_index];
        wait_index++;
        if (wb_we) begin
            if (exp_store_adr.size() == 0) begin
                fail_run($sformatf("store to %h that the model never makes", wb_adr));
            end
            check_value(wb_adr, exp_store_adr.pop_front(), "store address");
            check_value(wb_wdata, exp_store_dat.pop_front(), "store data");
        end else begin
            if (exp_load_adr.size() == 0) begin
                fail_run($sformatf("load from %h that the model never makes", wb_adr));
            end
            check_value(wb_adr, exp_load_adr.pop_front(), "load address");
        end
    endtask

    task automatic finish_request();
        if (req_we) begin
            slave_mem[req_adr] = wb_wdata;
        end else begin
            wb_rdata <= slave_mem.exists(req_adr) ? slave_mem[req_adr] : (req_adr ^ FILL_MASK);
        end
        wb_ack <= 1'b1;
    endtask

    always @(posedge clk_50MHz) begin
        if (wb_stb) begin
            check_value(16'(wb_cyc), 16'd1, "wb_stb high without wb_cyc");
        end
        if (wb_ack) begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_stb) begin
            if (!busy) begin
                start_request();
            end else begin
                // request must hold until ack
                check_value(wb_adr, req_adr, "wb_adr moved while waiting for ack");
                check_value(16'(wb_we), 16'(req_we), "wb_we moved while waiting for ack");
            end
            if (wait_left == 0) begin
                finish_request();
            end else begin
                wait_left--;
            end
        end
    end

    // ******************************
    // main sequence
    initial begin
        int    cycles;
        int    loops_seen;
        data_t self_addr;
        rst = 1'b0;
        void'($urandom(32'hf7ed_cc50));
        for (int i = 0; i < 64; i++) begin
            wait_table[i] = $urandom_range(0, 3);
        end
        build_program();
        run_model();

        repeat (16) begin
            @(posedge clk_50MHz);
            check_value(16'(wb_cyc), 16'd0, "wb_cyc during reset");
            check_value(16'(wb_stb), 16'd0, "wb_stb during reset");
            check_value(16'(wb_we), 16'd0, "wb_we during reset");
        end
        rst <= 1'b1;
        @(posedge clk_50MHz);
        check_value(imem_addr, RESET_PC, "first fetch address");
        check_value(16'(wb_cyc), 16'd0, "wb_cyc right after reset");
        check_value(16'(wb_stb), 16'd0, "wb_stb right after reset");
        check_value(16'(wb_we), 16'd0, "wb_we right after reset");

        cycles = 0;
        while (exp_store_adr.size() != 0) begin
            @(posedge clk_50MHz);
            cycles++;
            if (cycles > 3000) begin
                fail_run("timed out waiting for the expected stores");
            end
        end

        // fetch keeps coming back to the self loop
        self_addr  = RESET_PC + 16'(PROG_WORDS - 1);
        loops_seen = 0;
        cycles     = 0;
        while (loops_seen < 3) begin
            @(posedge clk_50MHz);
            cycles++;
            if (imem_addr == self_addr) begin
                loops_seen++;
            end
            if (cycles > 200) begin
                fail_run("timed out waiting for fetch to settle on the self loop");
            end
        end
        check_value(16'(exp_load_adr.size()), 16'd0, "loads still missing");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::data_t RESET_PC = '0
) (
    input  logic            clk_50MHz,
    input  logic            rst,
    input  cpu_pkg::instr_t imem_data,
    input  cpu_pkg::data_t  wb_rdata,
    input  logic            wb_ack,
    output cpu_pkg::data_t  imem_addr,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output cpu_pkg::data_t  wb_adr,
    output cpu_pkg::data_t  wb_wdata
);
    import cpu_pkg::*;

    // ******************************
    // stage to stage signals
    logic      freeze;
    logic      load_stall;
    logic      branch_taken;
    data_t     branch_target;
    instr_t    id_instr;
    data_t     id_pc_next;
    logic      id_valid;
    reg_addr_t id_rs_a;
    reg_addr_t id_rs_b;
    logic      id_reads_a;
    logic      id_reads_b;
    logic      ex_valid;
    alu_op_e   ex_alu_op;
    mem_op_e   ex_mem_op;
    branch_e   ex_branch;
    logic      ex_use_imm;
    data_t     ex_imm;
    data_t     ex_a;
    data_t     ex_b;
    data_t     ex_pc_next;
    reg_addr_t ex_rs_a;
    reg_addr_t ex_rs_b;
    reg_addr_t ex_rd;
    logic      ex_reg_write;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      mem_valid;
    mem_op_e   mem_op;
    data_t     mem_alu_result;
    data_t     mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      wb_reg_write;
    reg_addr_t wb_rd;
    data_t     wb_value;

    // port names match the signals above
    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    hazard_unit hazard_unit_inst (.*);

    execute_stage execute_stage_inst (.*);

    mem_wb_stage mem_wb_stage_inst (.*);

endmodule

/* rtl/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic               mem_valid,
    input  cpu_pkg::mem_op_e   mem_op,
    input  cpu_pkg::data_t     mem_alu_result,
    input  cpu_pkg::data_t     mem_store_data,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_reg_write,
    input  cpu_pkg::data_t     wb_rdata,
    input  logic               wb_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpu_pkg::data_t     wb_adr,
    output cpu_pkg::data_t     wb_wdata,
    output logic               freeze,
    output logic               wb_reg_write,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::data_t     wb_value
);
    import cpu_pkg::*;

    logic access;

    // wishbone classic, request held from EX/MEM until ack
    assign access   = mem_valid && (mem_op != MEM_NONE);
    assign wb_cyc   = access;
    assign wb_stb   = access;
    assign wb_we    = access && (mem_op == MEM_STORE);
    assign wb_adr   = mem_alu_result;
    assign wb_wdata = mem_store_data;
    assign freeze   = access && !wb_ack;

    // ******************************
    // MEM/WB register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_reg_write <= 1'b0;
        end else if (!freeze) begin
            wb_reg_write <= mem_valid && mem_reg_write;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!freeze) begin
            wb_rd    <= mem_rd;
            wb_value <= (mem_op == MEM_LOAD) ? wb_rdata : mem_alu_result;
        end
    end

    // a pending request is never dropped, stb always inside cyc
    a_req_held: assert property (@(posedge clk_50MHz) disable iff (!rst)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc));

    // the whole pipeline must hold the request still until ack
    a_req_stable: assert property (@(posedge clk_50MHz) disable iff (!rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we)));

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic               freeze,
    input  logic               ex_valid,
    input  cpu_pkg::alu_op_e   ex_alu_op,
    input  cpu_pkg::mem_op_e   ex_mem_op,
    input  cpu_pkg::branch_e   ex_branch,
    input  logic               ex_use_imm,
    input  cpu_pkg::data_t     ex_imm,
    input  cpu_pkg::data_t     ex_a,
    input  cpu_pkg::data_t     ex_b,
    input  cpu_pkg::data_t     ex_pc_next,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic               ex_reg_write,
    input  cpu_pkg::fwd_sel_e  fwd_a,
    input  cpu_pkg::fwd_sel_e  fwd_b,
    input  cpu_pkg::data_t     wb_value,
    output logic               branch_taken,
    output cpu_pkg::data_t     branch_target,
    output logic               mem_valid,
    output cpu_pkg::mem_op_e   mem_op,
    output cpu_pkg::data_t     mem_alu_result,
    output cpu_pkg::data_t     mem_store_data,
    output cpu_pkg::reg_addr_t mem_rd,
    output logic               mem_reg_write
);
    import cpu_pkg::*;

    data_t op_a;
    data_t op_b;
    data_t alu_b;
    data_t alu_y;

    function automatic data_t pick_operand(input fwd_sel_e sel, input data_t reg_val,
                                           input data_t mem_val, input data_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = pick_operand(fwd_a, ex_a, mem_alu_result, wb_value);
    assign op_b  = pick_operand(fwd_b, ex_b, mem_alu_result, wb_value);
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_y = op_a + alu_b;
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            default: alu_y = alu_b;
        endcase
    end

    // BEQZ tests the forwarded rx value
    assign branch_taken  = (ex_branch == BR_ALWAYS) || (ex_branch == BR_EQZ && op_a == '0);
    assign branch_target = ex_pc_next + ex_imm;

    // ******************************
    // EX/MEM register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_valid     <= 1'b0;
            mem_op        <= MEM_NONE;
            mem_reg_write <= 1'b0;
        end else if (!freeze) begin
            mem_valid     <= ex_valid;
            mem_op        <= ex_mem_op;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!freeze) begin
            mem_alu_result <= alu_y;
            mem_store_data <= op_b;
            mem_rd         <= ex_rd;
        end
    end

    // bubbles from decode never carry a branch kind
    a_taken_valid: assert property (@(posedge clk_50MHz) disable iff (!rst)
        branch_taken |-> ex_valid);

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rs_a,
    input  cpu_pkg::reg_addr_t id_rs_b,
    input  logic               id_reads_a,
    input  logic               id_reads_b,
    input  cpu_pkg::reg_addr_t ex_rs_a,
    input  cpu_pkg::reg_addr_t ex_rs_b,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic               ex_reg_write,
    input  cpu_pkg::mem_op_e   ex_mem_op,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_reg_write,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  logic               wb_reg_write,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               load_stall
);
    import cpu_pkg::*;

    // MEM holds the younger result, so it wins over WB
    function automatic fwd_sel_e pick_source(input reg_addr_t rs);
        if (mem_reg_write && mem_rd == rs) begin
            return FWD_MEM;
        end
        if (wb_reg_write && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = pick_source(ex_rs_a);
        fwd_b = pick_source(ex_rs_b);
    end

    // load data only exists after MEM, one bubble is needed
    assign load_stall = (ex_mem_op == MEM_LOAD) && ex_reg_write &&
                        ((id_reads_a && id_rs_a == ex_rd) ||
                         (id_reads_b && id_rs_b == ex_rd));

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic               freeze,
    input  logic               load_stall,
    input  logic               branch_taken,
    input  cpu_pkg::instr_t    id_instr,
    input  cpu_pkg::data_t     id_pc_next,
    input  logic               id_valid,
    input  logic               wb_reg_write,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::data_t     wb_value,
    output cpu_pkg::reg_addr_t id_rs_a,
    output cpu_pkg::reg_addr_t id_rs_b,
    output logic               id_reads_a,
    output logic               id_reads_b,
    output logic               ex_valid,
    output cpu_pkg::alu_op_e   ex_alu_op,
    output cpu_pkg::mem_op_e   ex_mem_op,
    output cpu_pkg::branch_e   ex_branch,
    output logic               ex_use_imm,
    output cpu_pkg::data_t     ex_imm,
    output cpu_pkg::data_t     ex_a,
    output cpu_pkg::data_t     ex_b,
    output cpu_pkg::data_t     ex_pc_next,
    output cpu_pkg::reg_addr_t ex_rs_a,
    output cpu_pkg::reg_addr_t ex_rs_b,
    output cpu_pkg::reg_addr_t ex_rd,
    output logic               ex_reg_write
);
    import cpu_pkg::*;

    opcode_e   opcode;
    reg_addr_t rx;
    reg_addr_t ry;
    reg_addr_t rz;
    reg_addr_t rd;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    branch_e   branch;
    logic      use_imm;
    logic      reg_write;
    logic      reads_a;
    logic      reads_b;
    logic      issue;
    data_t     imm;
    data_t     rd_data_a;
    data_t     rd_data_b;

    assign opcode = opcode_e'(id_instr[OPCODE_LSB +: 5]);
    assign rx     = id_instr[RX_LSB +: 3];
    assign ry     = id_instr[RY_LSB +: 3];
    assign rz     = id_instr[RZ_LSB +: 3];

    assign id_rs_a    = rx;
    assign id_rs_b    = ry;
    assign id_reads_a = id_valid && reads_a;
    assign id_reads_b = id_valid && reads_b;

    register_file register_file_inst (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rd_addr_a (rx),
        .rd_addr_b (ry),
        .wr_en     (wb_reg_write),
        .wr_addr   (wb_rd),
        .wr_data   (wb_value),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // ******************************
    // control decode
    always_comb begin
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        branch    = BR_NONE;
        use_imm   = 1'b0;
        imm       = '0;
        rd        = rx;
        reg_write = 1'b0;
        reads_a   = 1'b0;
        reads_b   = 1'b0;
        case (opcode)
            OP_B: begin
                branch = BR_ALWAYS;
                imm    = {{5{id_instr[10]}}, id_instr[10:0]};
            end
            OP_BEQZ: begin
                branch  = BR_EQZ;
                imm     = {{8{id_instr[7]}}, id_instr[7:0]};
                reads_a = 1'b1;
            end
            OP_ADDIU: begin
                use_imm   = 1'b1;
                imm       = {{8{id_instr[7]}}, id_instr[7:0]};
                reg_write = 1'b1;
                reads_a   = 1'b1;
            end
            OP_LI: begin
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                imm       = {8'h00, id_instr[7:0]};
                reg_write = 1'b1;
            end
            OP_LW: begin
                mem_op    = MEM_LOAD;
                use_imm   = 1'b1;
                imm       = {{11{id_instr[4]}}, id_instr[4:0]};
                rd        = ry;
                reg_write = 1'b1;
                reads_a   = 1'b1;
            end
            OP_SW: begin
                mem_op  = MEM_STORE;
                use_imm = 1'b1;
                imm     = {{11{id_instr[4]}}, id_instr[4:0]};
                reads_a = 1'b1;
                reads_b = 1'b1;
            end
            OP_RRR: begin
                alu_op    = (id_instr[1:0] == FN_SUBU) ? ALU_SUB : ALU_ADD;
                rd        = rz;
                reg_write = 1'b1;
                reads_a   = 1'b1;
                reads_b   = 1'b1;
            end
            OP_LOGIC: begin
                // rx = rx op ry, unknown functions do nothing
                alu_op    = (id_instr[4:0] == FN_OR) ? ALU_OR : ALU_AND;
                reg_write = (id_instr[4:0] == FN_AND) || (id_instr[4:0] == FN_OR);
                reads_a   = 1'b1;
                reads_b   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ******************************
    // ID/EX register
    assign issue = id_valid && !load_stall && !branch_taken;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_valid     <= 1'b0;
            ex_mem_op    <= MEM_NONE;
            ex_branch    <= BR_NONE;
            ex_reg_write <= 1'b0;
        end else if (!freeze) begin
            ex_valid     <= issue;
            ex_mem_op    <= issue ? mem_op : MEM_NONE;
            ex_branch    <= issue ? branch : BR_NONE;
            ex_reg_write <= issue && reg_write;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!freeze) begin
            ex_alu_op  <= alu_op;
            ex_use_imm <= use_imm;
            ex_imm     <= imm;
            ex_a       <= rd_data_a;
            ex_b       <= rd_data_b;
            ex_pc_next <= id_pc_next;
            ex_rs_a    <= rx;
            ex_rs_b    <= ry;
            ex_rd      <= rd;
        end
    end

    // an issued NOP reaches EX as a valid instruction without a write
    a_nop_no_write: assert property (@(posedge clk_50MHz) disable iff (!rst)
        (issue && !freeze && opcode == OP_NOP) |=> (ex_valid && !ex_reg_write));

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter cpu_pkg::data_t RESET_PC = '0
) (
    input  logic            clk_50MHz,
    input  logic            rst,
    input  logic            freeze,
    input  logic            load_stall,
    input  logic            branch_taken,
    input  cpu_pkg::data_t  branch_target,
    input  cpu_pkg::instr_t imem_data,
    output cpu_pkg::data_t  imem_addr,
    output cpu_pkg::instr_t id_instr,
    output cpu_pkg::data_t  id_pc_next,
    output logic            id_valid
);
    import cpu_pkg::*;

    data_t pc;
    data_t pc_plus_one;

    assign pc_plus_one = pc + 16'd1;
    assign imem_addr   = pc;

    // freeze first, then the taken branch, then the load stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc       <= RESET_PC;
            id_valid <= 1'b0;
        end else if (!freeze) begin
            if (branch_taken) begin
                pc       <= branch_target;
                id_valid <= 1'b0;
            end else if (!load_stall) begin
                pc       <= pc_plus_one;
                id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!freeze && !branch_taken && !load_stall) begin
            id_instr   <= imem_data;
            id_pc_next <= pc_plus_one;
        end
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rd_addr_a,
    input  cpu_pkg::reg_addr_t rd_addr_b,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::data_t     wr_data,
    output cpu_pkg::data_t     rd_data_a,
    output cpu_pkg::data_t     rd_data_b
);
    import cpu_pkg::*;

    data_t regs [NUM_REGS];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through, so decode sees the value written back this cycle
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] data_t;
    typedef logic [15:0] instr_t;
    typedef logic [2:0]  reg_addr_t;

    localparam int NUM_REGS = 8;

    // instruction field positions
    localparam int OPCODE_LSB = 11;
    localparam int RX_LSB     = 8;
    localparam int RY_LSB     = 5;
    localparam int RZ_LSB     = 2;

    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_LW    = 5'b10011,
        OP_SW    = 5'b11011,
        OP_RRR   = 5'b11100,
        OP_LOGIC = 5'b11101
    } opcode_e;

    // function fields, RRR in bits 1..0, LOGIC in bits 4..0
    localparam logic [1:0] FN_ADDU = 2'b01;
    localparam logic [1:0] FN_SUBU = 2'b11;
    localparam logic [4:0] FN_AND  = 5'b01100;
    localparam logic [4:0] FN_OR   = 5'b01101;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS_B} alu_op_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_ALWAYS, BR_EQZ} branch_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage
